//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
TOP       := afu_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test ok"; \
	else \
		echo "test FAILED, no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/afu.sv
// interrupt afu top, csr control, header rom, c1 interrupt and c2 response
`timescale 1ns/100ps

module afu #(
    parameter afu_pkg::t_csr_data AFU_ID_H      = 64'h3f1c_a720_5d84_4e9b,
    parameter afu_pkg::t_csr_data AFU_ID_L      = 64'hb06e_1d52_c9a3_7f18,
    parameter logic [3:0]         AFU_MAJOR_REV = 4'd1,
    parameter logic [3:0]         AFU_MINOR_REV = 4'd0
) (
    input  logic             Clk_400,   // core clock, host channel is synchronous to it
    input  logic             rst,       // sync, active high
    input  afu_pkg::t_afu_rx rx,        // mmio requests from host
    output afu_pkg::t_afu_tx tx         // interrupts on c1, read data on c2
);
    import afu_pkg::*;

    // ******************************
    // internal nets
    // ******************************
    logic      intr_fire;
    t_intr_id  intr_id;
    t_dfh_sel  dfh_sel;
    logic      rd_req;
    t_ccip_tid rd_tid;
    logic      rd_from_dfh;
    t_csr_data rd_csr_data;
    t_csr_data dfh_data;

    // address decode and registers
    afu_csr_ctrl u_csr_ctrl (
        .Clk_400     (Clk_400),
        .rst         (rst),
        .rx          (rx),
        .intr_fire   (intr_fire),
        .intr_id     (intr_id),
        .dfh_sel     (dfh_sel),
        .rd_req      (rd_req),
        .rd_tid      (rd_tid),
        .rd_from_dfh (rd_from_dfh),
        .rd_csr_data (rd_csr_data)
    );

    afu_dfh_rom #(
        .AFU_ID_H      (AFU_ID_H),
        .AFU_ID_L      (AFU_ID_L),
        .AFU_MAJOR_REV (AFU_MAJOR_REV),
        .AFU_MINOR_REV (AFU_MINOR_REV)
    ) u_dfh_rom (
        .dfh_sel  (dfh_sel),
        .dfh_data (dfh_data)
    );

    afu_intr_gen u_intr_gen (
        .Clk_400   (Clk_400),
        .rst       (rst),
        .intr_fire (intr_fire),
        .intr_id   (intr_id),
        .c1_tx     (tx.c1)      // c1 tx channel
    );

    afu_mmio_rsp u_mmio_rsp (
        .Clk_400     (Clk_400),
        .rst         (rst),
        .rd_req      (rd_req),
        .rd_tid      (rd_tid),
        .rd_from_dfh (rd_from_dfh),
        .rd_csr_data (rd_csr_data),
        .dfh_data    (dfh_data),
        .c2_tx       (tx.c2)    // c2 mmio response channel
    );

endmodule

//--- rtl/afu_csr_ctrl.sv
// mmio write and read decode, scratch and interrupt id registers
`timescale 1ns/100ps

module afu_csr_ctrl (
    input  logic                Clk_400,
    input  logic                rst,
    input  afu_pkg::t_afu_rx    rx,
    output logic                intr_fire,   // one cycle strobe to intr gen
    output afu_pkg::t_intr_id   intr_id,     // held id, level
    output afu_pkg::t_dfh_sel   dfh_sel,     // header word for the rom
    output logic                rd_req,      // read strobe to response stage
    output afu_pkg::t_ccip_tid  rd_tid,
    output logic                rd_from_dfh, // take rom word, not csr word
    output afu_pkg::t_csr_data  rd_csr_data
);
    import afu_pkg::*;

    t_mmio_addr addr;       // shared by reads and writes
    t_csr_data  scratch;    // host scratch register
    logic       wr_scratch; // write decodes
    logic       wr_intr_id;
    logic       in_hdr;     // address falls on a header word

    assign addr = rx.c0_hdr.address;

    // ******************************
    // write decode
    // ******************************
    assign wr_scratch = rx.mmio_wr_valid && (addr == CSR_SCRATCH);
    assign wr_intr_id = rx.mmio_wr_valid && (addr == CSR_INTR_ID);
    assign intr_fire  = rx.mmio_wr_valid && (addr == CSR_INTR);  // no storage

    always_ff @(posedge Clk_400) begin
        if (rst) begin
            scratch <= '0;
            intr_id <= '0;
        end else begin
            if (wr_scratch)
                scratch <= rx.c0_data;
            if (wr_intr_id)
                intr_id <= rx.c0_data[1:0];  // upper data bits ignored
        end
    end

    // ******************************
    // read decode
    // ******************************
    // header block sits on even words 0x00..0x08
    assign in_hdr = (addr <= DFH_LAST_ADDR) && !addr[0];

    // word index into the rom, 0x06 and 0x08 both map to zero
    always_comb begin
        if (addr[3:1] >= 3'd3)
            dfh_sel = DFH_SEL_ZERO;
        else
            dfh_sel = t_dfh_sel'(addr[2:1]);   // 0x00 hdr, 0x02 id l, 0x04 id h
    end

    // csr word, zero for anything unmapped
    always_comb begin
        case (addr)
            CSR_SCRATCH: rd_csr_data = scratch;
            CSR_INTR:    rd_csr_data = {{(CSR_DATA_W-2){1'b0}}, intr_id};
            default:     rd_csr_data = '0;
        endcase
    end

    assign rd_from_dfh = in_hdr;             // meaningful with rd_req only
    assign rd_req      = rx.mmio_rd_valid;
    assign rd_tid      = rx.c0_hdr.tid;      // passed through for the echo

endmodule

//--- rtl/afu_dfh_rom.sv
// device feature header and afu id words, selected by word index
`timescale 1ns/100ps

module afu_dfh_rom #(
    parameter afu_pkg::t_csr_data AFU_ID_H      = 64'h3f1c_a720_5d84_4e9b,
    parameter afu_pkg::t_csr_data AFU_ID_L      = 64'hb06e_1d52_c9a3_7f18,
    parameter logic [3:0]         AFU_MAJOR_REV = 4'd1,
    parameter logic [3:0]         AFU_MINOR_REV = 4'd0
) (
    input  afu_pkg::t_dfh_sel  dfh_sel,
    output afu_pkg::t_csr_data dfh_data
);
    import afu_pkg::*;

    t_csr_data dfh_word;

    // ******************************
    // feature header layout
    // ******************************
    assign dfh_word = {
        4'h1,            // [63:60] feature type afu
        AFU_MINOR_REV,   // [59:56] minor rev
        15'b0,           // [55:41] reserved
        1'b1,            // [40]    end of list, single feature
        24'b0,           // [39:16] next dfh offset
        AFU_MAJOR_REV,   // [15:12] major rev
        12'b0            // [11:0]  feature id
    };

    // word select
    always_comb begin
        case (dfh_sel)
            DFH_SEL_HDR:  dfh_data = dfh_word;
            DFH_SEL_ID_L: dfh_data = AFU_ID_L;   // low half first in the map
            DFH_SEL_ID_H: dfh_data = AFU_ID_H;
            default:      dfh_data = '0;          // next afu, reserved
        endcase
    end

endmodule

//--- rtl/afu_intr_gen.sv
// c1 interrupt request packet builder and output register
`timescale 1ns/100ps

module afu_intr_gen (
    input  logic              Clk_400,
    input  logic              rst,
    input  logic              intr_fire,  // from csr write decode
    input  afu_pkg::t_intr_id intr_id,    // value held before the edge
    output afu_pkg::t_c1_tx   c1_tx
);
    import afu_pkg::*;

    t_intr_req_hdr intr_hdr;   // combinational header
    t_c1_tx        intr_pkt;   // full packet ahead of the register

    // ******************************
    // header and packet
    // ******************************
    always_comb begin
        intr_hdr          = '0;         // reserved fields stay zero
        intr_hdr.vc_sel   = t_ccip_vc'(0);  // channel 0 only
        intr_hdr.req_type = REQ_INTR;
        intr_hdr.id       = intr_id;
    end

    always_comb begin
        intr_pkt       = '0;
        intr_pkt.hdr   = intr_hdr;
        intr_pkt.data  = '0;            // no payload for interrupts
        intr_pkt.valid = 1'b1;
    end

    // ******************************
    // output stage
    // ******************************
    // one valid cycle per strobe, channel cleared otherwise
    always_ff @(posedge Clk_400) begin
        if (rst) begin
            c1_tx <= '0;
        end else if (intr_fire) begin
            c1_tx <= intr_pkt;
        end else begin
            c1_tx <= '0;                // hdr and data zero between requests
        end
    end

endmodule

//--- rtl/afu_mmio_rsp.sv
// c2 mmio read response register, header or csr data select
`timescale 1ns/100ps

module afu_mmio_rsp (
    input  logic               Clk_400,
    input  logic               rst,
    input  logic               rd_req,       // read strobe
    input  afu_pkg::t_ccip_tid rd_tid,       // tid to echo
    input  logic               rd_from_dfh,  // pick rom word
    input  afu_pkg::t_csr_data rd_csr_data,  // csr word from ctrl
    input  afu_pkg::t_csr_data dfh_data,     // rom word
    output afu_pkg::t_c2_tx    c2_tx
);
    import afu_pkg::*;

    t_csr_data rsp_data;    // selected word ahead of the register

    // ******************************
    // data select
    // ******************************
    assign rsp_data = rd_from_dfh ? dfh_data : rd_csr_data;

    // ******************************
    // response stage
    // ******************************
    // valid pulses for one cycle per strobe
    always_ff @(posedge Clk_400) begin
        if (rst)
            c2_tx.mmio_rd_valid <= 1'b0;
        else
            c2_tx.mmio_rd_valid <= rd_req;  // back to back reads pass straight through
    end

    // data and tid hold between responses
    always_ff @(posedge Clk_400) begin
        if (rst) begin
            c2_tx.tid  <= '0;
            c2_tx.data <= '0;
        end else if (rd_req) begin
            c2_tx.tid  <= rd_tid;
            c2_tx.data <= rsp_data;
        end
    end

endmodule

//--- rtl/afu_pkg.sv
// channel widths, vector types, header and port structs, CSR address map
package afu_pkg;

    // ******************************
    // widths
    // ******************************
    localparam int MMIO_ADDR_W = 16;    // mmio word address
    localparam int CCIP_TID_W  = 9;     // host transaction id
    localparam int CSR_DATA_W  = 64;    // one mmio data word
    localparam int C1_HDR_W    = 80;    // c1 tx header
    localparam int C1_DATA_W   = 512;   // c1 tx data, one cache line

    // plain vector types
    typedef logic [MMIO_ADDR_W-1:0] t_mmio_addr;
    typedef logic [CCIP_TID_W-1:0]  t_ccip_tid;
    typedef logic [CSR_DATA_W-1:0]  t_csr_data;
    typedef logic [1:0]             t_intr_id;     // user interrupt 0..3
    typedef logic [1:0]             t_ccip_vc;     // virtual channel
    typedef logic [3:0]             t_req_type;    // c1 request code
    typedef logic [1:0]             t_dfh_sel;     // header word index

    // header word indices
    localparam t_dfh_sel DFH_SEL_HDR  = 2'd0;  // feature header
    localparam t_dfh_sel DFH_SEL_ID_L = 2'd1;  // afu id [63:0]
    localparam t_dfh_sel DFH_SEL_ID_H = 2'd2;  // afu id [127:64]
    localparam t_dfh_sel DFH_SEL_ZERO = 2'd3;  // next afu and reserved

    // ******************************
    // headers
    // ******************************
    // mmio request header as seen on c0 rx
    typedef struct packed {
        t_mmio_addr address;    // word address
        logic [1:0] length;     // access size, unused here
        logic       rsvd;
        t_ccip_tid  tid;        // echoed back on c2
    } t_mmio_req_hdr;           // 28 bits

    // interrupt request header, padded to the full c1 header width
    typedef struct packed {
        t_ccip_vc    vc_sel;    // always channel 0
        logic [9:0]  rsvd1;
        t_req_type   req_type;  // REQ_INTR
        logic [61:0] rsvd0;
        t_intr_id    id;        // which user interrupt
    } t_intr_req_hdr;           // 80 bits

    // ******************************
    // ports
    // ******************************
    typedef struct packed {
        t_mmio_req_hdr c0_hdr;
        t_csr_data     c0_data;        // write data
        logic          mmio_wr_valid;  // write strobe
        logic          mmio_rd_valid;  // read strobe
    } t_afu_rx;

    typedef struct packed {
        t_intr_req_hdr        hdr;
        logic [C1_DATA_W-1:0] data;    // interrupts carry no payload
        logic                 valid;
    } t_c1_tx;

    typedef struct packed {
        t_ccip_tid tid;
        t_csr_data data;
        logic      mmio_rd_valid;      // one cycle per response
    } t_c2_tx;

    typedef struct packed {
        t_c1_tx c1;
        t_c2_tx c2;
    } t_afu_tx;

    // ******************************
    // constants
    // ******************************
    localparam t_req_type REQ_INTR = 4'hc;   // interrupt request code

    localparam t_mmio_addr CSR_SCRATCH   = 16'h0020;  // scratch, r/w
    localparam t_mmio_addr CSR_INTR      = 16'h0028;  // w fires irq, r gives id
    localparam t_mmio_addr CSR_INTR_ID   = 16'h0030;  // w sets irq id
    localparam t_mmio_addr DFH_LAST_ADDR = 16'h0008;  // end of header block

endpackage

//--- tests/afu_cases.txt
# op addr data tid expect_rd intr_flag intr_id
# op W write, R read, I idle; tid r = random; expect dfh/idl/idh from params, - for none
I 0000 0 r - 0 0
I 0000 0 r - 0 0
R 0028 0 r 0 0 0
R 0000 0 r dfh 0 0
I 0000 0 r - 0 0
R 0002 0 r idl 0 0
R 0004 0 r idh 0 0
R 0006 0 r 0 0 0
R 0008 0 r 0 0 0
W 0020 0123456789abcdef r - 0 0
I 0000 0 r - 0 0
R 0020 0 1ff 0123456789abcdef 0 0
R 0010 0 r 0 0 0
R 0003 0 r 0 0 0
R 0040 0 r 0 0 0
W 0030 2 r - 0 0
W 0028 0 r - 1 2
I 0000 0 r - 0 0
R 0028 0 r 2 0 0
W 0030 fffffffffffffffd r - 0 0
W 0028 0 r - 1 1
W 0020 f0e1d2c3b4a59687 r - 0 0
R 0020 0 r f0e1d2c3b4a59687 0 0
R 0000 0 r dfh 0 0
R 0028 0 r 1 0 0
R 0004 0 005 idh 0 0
R 0002 0 r idl 0 0
I 0000 0 r - 0 0
I 0000 0 r - 0 0

//--- tests/afu_tb.sv
// testbench top with case file loader, dut instance, stimulus, output checks and timeout
`timescale 1ns/100ps

module afu_tb;
    import afu_pkg::*;

    // ******************************
    // dut setup
    // ******************************
    localparam t_csr_data  ID_H      = 64'h5a17_c3e0_9b42_d681;  // not the rtl defaults
    localparam t_csr_data  ID_L      = 64'h0f9e_27b4_a13c_58d6;
    localparam logic [3:0] MAJOR_REV = 4'd3;
    localparam logic [3:0] MINOR_REV = 4'd2;
    localparam string      CASE_FILE = "tests/afu_cases.txt";

    // one operation from the case file
    typedef struct packed {
        logic       is_wr;
        logic       is_rd;
        t_mmio_addr addr;
        t_csr_data  data;       // write data
        t_ccip_tid  tid;
        t_csr_data  exp_data;   // expected read word, only used with is_rd
        logic       exp_intr;   // c1 packet expected one cycle later
        t_intr_id   exp_id;
    } t_case;

    logic    Clk_400;
    logic    rst;
    t_afu_rx rx;
    t_afu_tx tx;

    t_case cases[$];
    int    seed        = 32'h8e2d_eb5e;  // tid generator state
    int    cycle_count = 0;
    int    cycle_limit = 0;              // zero until the cases are loaded
    int    error_count = 0;

    tb_clk_gen u_clk_gen (.Clk_400(Clk_400), .rst(rst));

    afu #(
        .AFU_ID_H      (ID_H),
        .AFU_ID_L      (ID_L),
        .AFU_MAJOR_REV (MAJOR_REV),
        .AFU_MINOR_REV (MINOR_REV)
    ) uut (
        .Clk_400 (Clk_400),
        .rst     (rst),
        .rx      (rx),
        .tx      (tx)
    );

    // ******************************
    // helpers
    // ******************************
    task automatic fail_run();
        error_count++;
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    // feature header built field by field from the bit map
    function automatic t_csr_data expected_dfh();
        t_csr_data w;
        w          = '0;
        w[63:60]   = 4'h1;        // afu feature type
        w[59:56]   = MINOR_REV;
        w[40]      = 1'b1;        // end of list
        w[15:12]   = MAJOR_REV;
        return w;
    endfunction

    // reads the whole file into the case queue and draws the tids
    task automatic load_cases();
        int                fd;
        int                cnt;
        int                rnd;
        int                intr_f;
        logic [8*160-1:0]  line;
        string             op_s;
        string             tid_s;
        string             exp_s;
        t_mmio_addr        addr_v;
        t_csr_data         data_v;
        t_csr_data         exp_v;
        t_ccip_tid         tid_v;
        t_intr_id          id_v;
        t_case             c;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", CASE_FILE);
            fail_run();
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) == 0)
                    continue;
                cnt = $sscanf(line, "%s %h %h %s %s %d %h",
                              op_s, addr_v, data_v, tid_s, exp_s, intr_f, id_v);
                if (cnt < 1 || op_s.substr(0, 0) == "#")
                    continue;                       // blank or column notes
                if (cnt != 7 || !(op_s == "W" || op_s == "R" || op_s == "I")) begin
                    $display("bad line in the case file: %0s", line);
                    fail_run();
                end else begin
                    c        = '0;
                    c.is_wr  = (op_s == "W");
                    c.is_rd  = (op_s == "R");
                    c.addr   = addr_v;
                    c.data   = data_v;
                    if (tid_s == "r") begin
                        rnd   = $random(seed);
                        c.tid = rnd[8:0];
                    end else begin
                        cnt   = $sscanf(tid_s, "%h", tid_v);
                        c.tid = tid_v;
                    end
                    // header words come from the parameters set above
                    if (exp_s == "dfh")
                        exp_v = expected_dfh();
                    else if (exp_s == "idl")
                        exp_v = ID_L;
                    else if (exp_s == "idh")
                        exp_v = ID_H;
                    else if (exp_s == "-")
                        exp_v = '0;                 // no read on this line
                    else
                        cnt = $sscanf(exp_s, "%h", exp_v);
                    c.exp_data = exp_v;
                    c.exp_intr = (intr_f != 0);
                    c.exp_id   = id_v;
                    cases.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_case(input t_case c);
        rx.c0_hdr.address = c.addr;
        rx.c0_hdr.length  = 2'b00;
        rx.c0_hdr.rsvd    = 1'b0;
        rx.c0_hdr.tid     = c.tid;
        rx.c0_data        = c.data;
        rx.mmio_wr_valid  = c.is_wr;
        rx.mmio_rd_valid  = c.is_rd;
    endtask

    // both channels checked one cycle after the request
    task automatic check_response(input t_case c);
        check_value("tx.c2.mmio_rd_valid", 64'(tx.c2.mmio_rd_valid), 64'(c.is_rd));
        if (c.is_rd) begin
            check_value("tx.c2.tid", 64'(tx.c2.tid), 64'(c.tid));
            check_value("tx.c2.data", tx.c2.data, c.exp_data);
        end
        check_value("tx.c1.valid", 64'(tx.c1.valid), 64'(c.exp_intr));
        if (c.exp_intr) begin
            check_value("tx.c1.hdr.id", 64'(tx.c1.hdr.id), 64'(c.exp_id));
            check_value("tx.c1.hdr.req_type", 64'(tx.c1.hdr.req_type), 64'(REQ_INTR));
            check_value("tx.c1.hdr.vc_sel", 64'(tx.c1.hdr.vc_sel), 64'(0));
            check_value("tx.c1.hdr.rsvd1", 64'(tx.c1.hdr.rsvd1), 64'(0));
            check_value("tx.c1.hdr.rsvd0", 64'(tx.c1.hdr.rsvd0), 64'(0));
        end else begin
            assert (tx.c1.hdr == '0) else begin
                $display("ERR tx.c1.hdr: got 0x%h, expected 0x%h", tx.c1.hdr, 80'h0);
                fail_run();
            end
        end
        // no payload on c1 in any cycle
        assert (tx.c1.data == '0) else begin
            $display("ERR tx.c1.data: got 0x%h, expected 0x0", tx.c1.data);
            fail_run();
        end
    endtask

    // ******************************
    // main sequence
    // ******************************
    initial begin
        rx = '0;                            // strobes low from time 0
        load_cases();
        cycle_limit = cases.size() * 4 + 50;
        @(negedge Clk_400);
        while (rst)
            @(negedge Clk_400);
        foreach (cases[k]) begin
            drive_case(cases[k]);           // falling edge drive
            @(negedge Clk_400);             // dut registered it at the rising edge between
            check_response(cases[k]);
        end
        rx = '0;
        if (error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            fail_run();
        end
    end

    // run limit from the case count
    always @(posedge Clk_400) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            fail_run();
        end
    end

endmodule

//--- tests/tb_clk_gen.sv
// testbench clock and reset generator, 4 ns clock, reset held for a few cycles
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int HALF_PERIOD = 2,   // ns, gives a 4 ns period
    parameter int RST_CYCLES  = 3    // rising edges with reset high
) (
    output logic Clk_400,
    output logic rst
);

    initial begin
        Clk_400 = 1'b0;
        forever #(HALF_PERIOD) Clk_400 = ~Clk_400;
    end

    // released right after the last reset edge, so the dut sees it on RST_CYCLES edges
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge Clk_400);
        rst <= 1'b0;
    end

endmodule

//--- verilog.f
rtl/afu_pkg.sv
rtl/afu_csr_ctrl.sv
rtl/afu_dfh_rom.sv
rtl/afu_intr_gen.sv
rtl/afu_mmio_rsp.sv
rtl/afu.sv
tests/tb_clk_gen.sv
tests/afu_tb.sv
